/* src.f */
verilog/pq_pkg.sv
verilog/pq_bram.sv
verilog/pq_compare_swap.sv
verilog/pq_control_fsm.sv
verilog/pq_top.sv
testbench/pq_tb.sv

/* testbench/pq_cases.txt */
# op test value dropped  (E enqueue value, D dequeue with expected head entry,
# R random phase with hex op count in value); value is hex key:tag, test is decimal
D 1 ffffffff 1
E 2 00050001 0
E 2 00020002 0
E 2 00090003 0
E 2 00010004 0
D 2 00010004 0
D 2 00020002 0
D 2 00050001 0
D 2 00090003 0
E 3 00040011 0
E 3 00040012 0
E 3 00030013 0
E 3 00040014 0
D 3 00030013 0
D 3 00040011 0
D 3 00040012 0
D 3 00040014 0
E 4 00080041 0
E 4 00030042 0
E 4 000c0043 0
E 4 00010044 0
E 4 000f0045 0
E 4 00060046 0
E 4 000a0047 0
E 4 00020048 0
E 4 000e0049 0
E 4 0005004a 0
E 4 0009004b 0
E 4 0010004c 0
E 4 0004004d 0
E 4 000b004e 0
E 4 0007004f 0
E 4 000d0050 0
E 4 00000099 1
D 4 00010044 0
D 5 00020048 0
D 5 00030042 0
D 5 0004004d 0
D 5 0005004a 0
D 5 00060046 0
D 5 0007004f 0
D 5 00080041 0
D 5 0009004b 0
D 5 000a0047 0
D 5 000b004e 0
D 5 000c0043 0
D 5 000d0050 0
D 5 000e0049 0
D 5 000f0045 0
E 5 00120061 0
E 5 00110062 0
D 5 0010004c 0
D 5 00110062 0
D 5 00120061 0
D 5 ffffffff 1
R 6 000000c8 0

/* testbench/pq_tb.sv */
`timescale 1ns/100ps

module pq_tb
  import pq_pkg::*;
();

  logic      clk;
  logic      rst;
  logic      enq;
  logic      deq;
  pq_entry_u data_in;
  logic      busy;
  logic      done;
  logic      dropped;
  pq_entry_u data_out;
  logic      full;
  logic      empty;

  // Cases as read from the file
  logic [7:0]  case_op [$];
  int          case_test [$];
  logic [31:0] case_val [$];
  logic        case_drop [$];

  // Sorted reference queue with the head at index 0
  pq_entry_u   model_q [$];
  // Head of the last accepted dequeue
  pq_entry_u   last_out;

  logic [31:0] lcg_state;
  int          op_total;
  int          cur_test;
  int          test_err;
  int          tests_ok;
  int          tests_bad;
  logic        loaded;

  pq_top DUT (
    .clk      (clk),
    .rst      (rst),
    .enq      (enq),
    .deq      (deq),
    .data_in  (data_in),
    .busy     (busy),
    .done     (done),
    .dropped  (dropped),
    .data_out (data_out),
    .full     (full),
    .empty    (empty)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model and stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Stable insert behind every entry with an equal key
  task automatic model_enq(input pq_entry_u v, output logic drop);
    int pos;
    drop = (model_q.size() == PQ_DEPTH);
    if (!drop)
    begin
      pos = 0;
      while (pos < model_q.size() && model_q[pos].f.key <= v.f.key)
        pos++;
      model_q.insert(pos, v);
    end
  endtask

  task automatic model_deq(output pq_entry_u v, output logic drop);
    drop  = (model_q.size() == 0);
    v.raw = PQ_EMPTY_WORD;
    if (!drop)
      v = model_q.pop_front();
  endtask

  // One strobe on the falling edge, then wait for done
  task automatic issue(input logic is_enq, input pq_entry_u v);
    @(negedge clk);
    enq     = is_enq;
    deq     = !is_enq;
    data_in = v;
    @(negedge clk);
    enq = 1'b0;
    deq = 1'b0;
    while (done !== 1'b1)
      @(negedge clk);
  endtask

  // Predict, run, and compare against the model
  task automatic run_op(input logic is_enq, input pq_entry_u v,
                        output pq_entry_u exp_data, output logic exp_drop);
    exp_data.raw = PQ_EMPTY_WORD;
    if (is_enq)
      model_enq(v, exp_drop);
    else
      model_deq(exp_data, exp_drop);
    // data_out keeps the last accepted head until the next dequeue
    if (!is_enq && !exp_drop)
      last_out = exp_data;
    issue(is_enq, v);
    assert (dropped === exp_drop)
    else
    begin
      $display("mismatch at %0t: %s dropped %b, expected %b", $time,
               is_enq ? "enqueue" : "dequeue", dropped, exp_drop);
      test_err++;
    end
    assert (data_out.raw === last_out.raw)
    else
    begin
      $display("mismatch at %0t: data_out %h, expected %h", $time,
               data_out.raw, last_out.raw);
      test_err++;
    end
    assert (full === (model_q.size() == PQ_DEPTH) && empty === (model_q.size() == 0))
    else
    begin
      $display("mismatch at %0t: full %b empty %b with %0d entries", $time,
               full, empty, model_q.size());
      test_err++;
    end
  endtask

  task automatic random_phase(input int ops);
    pq_entry_u v;
    pq_entry_u exp_data;
    logic      exp_drop;
    for (int i = 0; i < ops; i++)
    begin
      lcg_state = lcg_next(lcg_state);
      // Narrow key range for plenty of ties
      v.f.key = PQ_KEY_W'(lcg_state[27:24]);
      v.f.tag = PQ_TAG_W'(i);
      // About five enqueues in eight so that full gets hit
      run_op(lcg_state[30:28] < 3'd5, v, exp_data, exp_drop);
    end
  endtask

  task automatic load_cases(output logic ok);
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    int          tn;
    logic [31:0] val;
    int          fl;
    ok = 1'b0;
    fd = $fopen("testbench/pq_cases.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while (!$feof(fd))
      begin
        n = $fgets(line, fd);
        // Skip comments and blank lines
        if (n > 1 && line[0] != "#")
        begin
          n = $sscanf(line, "%c %d %h %d", op, tn, val, fl);
          if (n == 4)
          begin
            case_op.push_back(op);
            case_test.push_back(tn);
            case_val.push_back(val);
            case_drop.push_back(fl != 0);
            op_total += (op == "R") ? int'(val) : 1;
          end
          else
          begin
            $display("unreadable line in the case file: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic close_test();
    if (test_err == 0)
    begin
      tests_ok++;
      $display("case %0d: ok", cur_test);
    end
    else
    begin
      tests_bad++;
      $display("case %0d: %0d errors", cur_test, test_err);
    end
    test_err = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    pq_entry_u exp_data;
    logic      exp_drop;
    clk          = 1'b0;
    rst          = 1'b1;
    enq          = 1'b0;
    deq          = 1'b0;
    data_in      = '0;
    last_out.raw = PQ_EMPTY_WORD;
    op_total     = 0;
    cur_test     = 1;
    test_err     = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    lcg_state    = 32'd24702;
    load_cases(loaded);
    if (!loaded)
    begin
      $display("could not read the case file testbench/pq_cases.txt");
      $display("test failed");
      $finish;
    end
    else
    begin
      repeat (8) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      // Idle and empty out of reset
      assert (empty === 1'b1 && full === 1'b0 && busy === 1'b0 && done === 1'b0 &&
              data_out.raw === PQ_EMPTY_WORD)
      else
      begin
        $display("mismatch at %0t: after reset empty %b full %b busy %b done %b data_out %h",
                 $time, empty, full, busy, done, data_out.raw);
        test_err++;
      end
      foreach (case_op[i])
      begin
        if (case_test[i] != cur_test)
        begin
          close_test();
          cur_test = case_test[i];
        end
        if (case_op[i] == "R")
          random_phase(int'(case_val[i]));
        else
        begin
          run_op(case_op[i] == "E", case_val[i], exp_data, exp_drop);
          assert (exp_drop === case_drop[i] &&
                  (case_op[i] == "E" || exp_drop || exp_data.raw === case_val[i]))
          else
          begin
            $display("case file entry %0d of test %0d disagrees with the reference model",
                     i, cur_test);
            test_err++;
          end
        end
      end
      close_test();
      $display("%0d tests ok, %0d tests with errors", tests_ok, tests_bad);
      if (tests_bad == 0)
      begin
        $display("test passed");
      end
      else
      begin
        $display("test failed");
      end
      $finish;
    end
  end

  // Worst case per operation is a full insertion walk
  initial
  begin
    wait (op_total > 0);
    repeat (op_total * (4 * PQ_DEPTH + 10) + 8) @(posedge clk);
    $display("timeout: the DUT did not finish all operations in the expected time");
    $display("test failed");
    $finish;
  end

endmodule

/* verilog/pq_top.sv */
`timescale 1ns/100ps

module pq_top
  import pq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      enq,
  input  logic      deq,
  input  pq_entry_u data_in,
  output logic      busy,
  output logic      done,
  output logic      dropped,
  output pq_entry_u data_out,
  output logic      full,
  output logic      empty
);

  // Controller to memory
  logic                 re;
  logic                 we;
  logic [PQ_ADDR_W-1:0] rd_addr;
  logic [PQ_ADDR_W-1:0] wr_addr;
  pq_entry_u            wr_data;
  pq_entry_u            rd_data;

  // Controller to datapath
  pq_sel_e   sel;
  logic      less;
  pq_entry_u swap_out;

  //////////////////////////////////////////////////////////////////////
  // Slot memory
  //////////////////////////////////////////////////////////////////////

  pq_bram u_bram (
    .clk     (clk),
    .re      (re),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .we      (we),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  // Temp register and key comparator
  pq_compare_swap u_compare_swap (
    .clk      (clk),
    .rst      (rst),
    .sel      (sel),
    .data_in  (data_in),
    .rd_data  (rd_data),
    .less     (less),
    .swap_out (swap_out)
  );

  // Sequencer
  pq_control_fsm u_control_fsm (
    .clk      (clk),
    .rst      (rst),
    .enq      (enq),
    .deq      (deq),
    .less     (less),
    .rd_data  (rd_data),
    .swap_out (swap_out),
    .sel      (sel),
    .re       (re),
    .rd_addr  (rd_addr),
    .we       (we),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .busy     (busy),
    .done     (done),
    .dropped  (dropped),
    .data_out (data_out),
    .full     (full),
    .empty    (empty)
  );

endmodule

/* verilog/pq_control_fsm.sv */
`timescale 1ns/100ps

module pq_control_fsm
  import pq_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 enq,
  input  logic                 deq,
  input  logic                 less,
  input  pq_entry_u            rd_data,
  input  pq_entry_u            swap_out,
  output pq_sel_e              sel,
  output logic                 re,
  output logic [PQ_ADDR_W-1:0] rd_addr,
  output logic                 we,
  output logic [PQ_ADDR_W-1:0] wr_addr,
  output pq_entry_u            wr_data,
  output logic                 busy,
  output logic                 done,
  output logic                 dropped,
  output pq_entry_u            data_out,
  output logic                 full,
  output logic                 empty
);

  logic [PQ_ST_W-1:0]  state;
  logic [PQ_ST_W-1:0]  next;
  // Slot index runs to count, so it needs the count width
  logic [PQ_CNT_W-1:0] idx;
  logic [PQ_CNT_W-1:0] idx_prev;
  logic [PQ_CNT_W-1:0] count;
  // Set after the first swap of an insertion
  logic                shifting;
  logic                fill_empty;
  logic                at_end;

  // Status from occupancy
  assign full     = (count == PQ_CNT_W'(PQ_DEPTH));
  assign empty    = (count == '0);
  assign busy     = (state != ST_IDLE);
  assign at_end   = (idx == count);
  assign idx_prev = idx - 1'b1;

  // Freed tail slot gets the empty marker
  assign wr_data = fill_empty ? pq_entry_u'(PQ_EMPTY_WORD) : swap_out;

  //////////////////////////////////////////////////////////////////////
  // Next state and datapath strobes
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next       = state;
    sel        = SEL_HOLD;
    re         = 1'b0;
    rd_addr    = idx[PQ_ADDR_W-1:0];
    we         = 1'b0;
    wr_addr    = idx[PQ_ADDR_W-1:0];
    fill_empty = 1'b0;
    case (state)
      ST_IDLE:
      begin
        // enq wins over deq
        if (enq)
        begin
          if (full)
            next = ST_DROP;
          else
          begin
            sel  = SEL_INPUT;
            next = ST_FILL_ENQ;
          end
        end
        else if (deq)
        begin
          if (empty)
            next = ST_DROP;
          else
          begin
            // Head read issued right away
            re      = 1'b1;
            rd_addr = '0;
            next    = ST_DEQ_LOCATE;
          end
        end
      end
      // Read stored slot, or park the held entry in the first free slot
      ST_FILL_ENQ:
      begin
        if (at_end)
        begin
          we   = 1'b1;
          next = ST_ENQ_DONE;
        end
        else
        begin
          re   = 1'b1;
          next = ST_COMPARE_ENQ;
        end
      end
      // Once displaced, every later slot moves down one
      // so equal keys keep arrival order
      ST_COMPARE_ENQ:
        next = (less || shifting) ? ST_SWAP_ENQ : ST_IDX_INC;
      ST_SWAP_ENQ:
      begin
        we   = 1'b1;
        sel  = SEL_MEM;
        next = ST_IDX_INC;
      end
      ST_IDX_INC:
        next = ST_FILL_ENQ;
      ST_ENQ_DONE:
        next = ST_IDLE;
      ST_DEQ_LOCATE:
        next = ST_DEQ_READ;
      ST_DEQ_READ:
      begin
        if (at_end)
          next = ST_FILL_DEQ;
        else
        begin
          re   = 1'b1;
          next = ST_DEQ_LOAD;
        end
      end
      ST_DEQ_LOAD:
      begin
        sel  = SEL_MEM;
        next = ST_DEQ_SHIFT;
      end
      // Move up one slot
      ST_DEQ_SHIFT:
      begin
        we      = 1'b1;
        wr_addr = idx_prev[PQ_ADDR_W-1:0];
        next    = ST_DEQ_READ;
      end
      ST_FILL_DEQ:
      begin
        we         = 1'b1;
        wr_addr    = idx_prev[PQ_ADDR_W-1:0];
        fill_empty = 1'b1;
        next       = ST_CNT_DEC;
      end
      ST_CNT_DEC:
        next = ST_DEQ_DONE;
      ST_DEQ_DONE, ST_DROP:
        next = ST_IDLE;
      default:
        next = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // State, index, count and result registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      idx      <= '0;
      count    <= '0;
      shifting <= 1'b0;
      done     <= 1'b0;
      dropped  <= 1'b0;
      data_out <= pq_entry_u'(PQ_EMPTY_WORD);
    end
    else
    begin
      state   <= next;
      done    <= (state == ST_ENQ_DONE) || (state == ST_DEQ_DONE) || (state == ST_DROP);
      dropped <= (state == ST_DROP);
      case (state)
        ST_IDLE:
        begin
          idx      <= '0;
          shifting <= 1'b0;
        end
        ST_SWAP_ENQ:
          shifting <= 1'b1;
        ST_IDX_INC, ST_DEQ_SHIFT:
          idx <= idx + 1'b1;
        ST_ENQ_DONE:
          count <= count + 1'b1;
        // Head captured, shifting starts from slot 1
        ST_DEQ_LOCATE:
        begin
          data_out <= rd_data;
          idx      <= PQ_CNT_W'(1);
        end
        ST_CNT_DEC:
          count <= count - 1'b1;
      endcase
    end
  end

endmodule

/* verilog/pq_compare_swap.sv */
`timescale 1ns/100ps

module pq_compare_swap
  import pq_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  pq_sel_e   sel,
  input  pq_entry_u data_in,
  input  pq_entry_u rd_data,
  output logic      less,
  output pq_entry_u swap_out
);

  // Entry in flight
  pq_entry_u tmp;
  pq_entry_u tmp_next;

  //////////////////////////////////////////////////////////////////////
  // Source select for the temp register
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (sel)
      SEL_INPUT:
        tmp_next = data_in;
      // Displaced or shifted entry comes back from memory
      SEL_MEM:
        tmp_next = rd_data;
      default:
        tmp_next = tmp;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tmp.raw <= PQ_EMPTY_WORD;
    end
    else
    begin
      tmp <= tmp_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Key compare and swap path
  //////////////////////////////////////////////////////////////////////

  // Strict compare, an equal key never overtakes
  assign less = (tmp.f.key < rd_data.f.key);

  // Held entry goes to memory on a swap or shift
  assign swap_out = tmp;

endmodule

/* verilog/pq_bram.sv */
`timescale 1ns/100ps

module pq_bram
  import pq_pkg::*;
(
  input  logic                 clk,
  input  logic                 re,
  input  logic [PQ_ADDR_W-1:0] rd_addr,
  output pq_entry_u            rd_data,
  input  logic                 we,
  input  logic [PQ_ADDR_W-1:0] wr_addr,
  input  pq_entry_u            wr_data
);

  // One raw word per queue slot, head at address 0
  logic [PQ_DATA_W-1:0] mem [PQ_DEPTH];

  // Single write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[wr_addr] <= wr_data.raw;
    end
  end

  // Registered read, output holds while re is low
  always_ff @(posedge clk)
  begin
    if (re)
    begin
      rd_data.raw <= mem[rd_addr];
    end
  end

endmodule

/* verilog/pq_pkg.sv */
package pq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Queue geometry
  //////////////////////////////////////////////////////////////////////

  localparam int PQ_DEPTH  = 16;
  localparam int PQ_ADDR_W = 4;
  // One extra bit so a full queue of 16 fits
  localparam int PQ_CNT_W  = 5;

  // Entry word is key in the upper half, tag below it
  localparam int PQ_DATA_W = 32;
  localparam int PQ_KEY_W  = 16;
  localparam int PQ_TAG_W  = PQ_DATA_W - PQ_KEY_W;

  // Free slot marker
  localparam logic [PQ_DATA_W-1:0] PQ_EMPTY_WORD = '1;

  // Sequencer state codes
  localparam int PQ_ST_W = 4;
  localparam logic [PQ_ST_W-1:0] ST_IDLE        = 4'h0;
  localparam logic [PQ_ST_W-1:0] ST_FILL_ENQ    = 4'h1;
  localparam logic [PQ_ST_W-1:0] ST_COMPARE_ENQ = 4'h2;
  localparam logic [PQ_ST_W-1:0] ST_SWAP_ENQ    = 4'h3;
  localparam logic [PQ_ST_W-1:0] ST_IDX_INC     = 4'h4;
  localparam logic [PQ_ST_W-1:0] ST_ENQ_DONE    = 4'h5;
  localparam logic [PQ_ST_W-1:0] ST_DEQ_LOCATE  = 4'h6;
  localparam logic [PQ_ST_W-1:0] ST_DEQ_READ    = 4'h7;
  localparam logic [PQ_ST_W-1:0] ST_DEQ_LOAD    = 4'h8;
  localparam logic [PQ_ST_W-1:0] ST_DEQ_SHIFT   = 4'h9;
  localparam logic [PQ_ST_W-1:0] ST_FILL_DEQ    = 4'ha;
  localparam logic [PQ_ST_W-1:0] ST_CNT_DEC     = 4'hb;
  localparam logic [PQ_ST_W-1:0] ST_DEQ_DONE    = 4'hc;
  localparam logic [PQ_ST_W-1:0] ST_DROP        = 4'hd;

  //////////////////////////////////////////////////////////////////////
  // Entry word and temp register source select
  //////////////////////////////////////////////////////////////////////

  // Raw view for memory and empty checks, field view for the comparator
  typedef union packed {
    logic [PQ_DATA_W-1:0] raw;
    struct packed {
      logic [PQ_KEY_W-1:0] key;
      logic [PQ_TAG_W-1:0] tag;
    } f;
  } pq_entry_u;

  typedef enum logic [1:0] {
    SEL_HOLD  = 2'd0,
    SEL_INPUT = 2'd1,
    SEL_MEM   = 2'd2
  } pq_sel_e;

endpackage
